/* hw/fifo_pkg.sv */
package fifo_pkg;

    // --------------------------------------------------
    // FIFO sizes
    // --------------------------------------------------
    localparam int DATA_W     = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

    typedef logic [DATA_W-1:0] data_t;

    // --------------------------------------------------
    // AXI4-Lite port
    // --------------------------------------------------
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    typedef enum logic [1:0] {
        REG_CONTROL,
        REG_INFO,
        REG_STATUS,
        REG_PTRS
    } reg_idx_t;

    localparam logic [AXIL_ADDR_W-1:0] ADDR_CONTROL = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_INFO    = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS  = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_PTRS    = 8'h0C;

    // Field positions
    localparam int CTRL_SOFT_RST  = 0;
    localparam int INFO_DEPTH_LSB = 0;
    localparam int INFO_WIDTH_LSB = 16;
    localparam int STAT_FULL      = 0;
    localparam int STAT_EMPTY     = 1;
    localparam int STAT_OFLOW     = 2;
    localparam int STAT_UFLOW     = 3;
    localparam int STAT_COUNT_LSB = 8;
    localparam int PTRS_WR_LSB    = 0;
    localparam int PTRS_RD_LSB    = 8;

endpackage

/* hw/fifo_core.sv */
`timescale 1ns/1ps

module fifo_core (
    input  logic                      wr_clk,
    input  logic                      i_rst_n,
    input  logic                      i_soft_rst,
    input  logic                      i_wr,
    input  fifo_pkg::data_t           i_wr_data,
    input  logic                      i_rd,
    output fifo_pkg::data_t           o_rd_data,
    output logic                      o_full,
    output logic                      o_empty,
    output logic [fifo_pkg::CNT_W-1:0] o_count,
    output logic                      o_oflow,
    output logic                      o_uflow,
    output logic [fifo_pkg::PTR_W-1:0] o_wr_ptr,
    output logic [fifo_pkg::PTR_W-1:0] o_rd_ptr
);
    import fifo_pkg::*;

    // --------------------------------------------------
    // Storage and state
    // --------------------------------------------------
    data_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             full;
    logic             empty;
    logic             oflow;
    logic             uflow;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Blocked operations are dropped here
    assign push = i_wr && !full && !i_soft_rst;
    assign pop  = i_rd && !empty && !i_soft_rst;

    always_comb begin
        count_nxt = count;
        case ({push, pop})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;
        endcase
    end

    // Payload array
    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // --------------------------------------------------
    // Pointers, count, flags
    // --------------------------------------------------
    always_ff @(posedge wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
            oflow  <= 1'b0;
            uflow  <= 1'b0;
        end else if (i_soft_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
            oflow  <= 1'b0;
            uflow  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count_nxt;
            full  <= (count_nxt == CNT_W'(FIFO_DEPTH));
            empty <= (count_nxt == '0);
            // One-cycle pulses for dropped requests
            oflow <= i_wr && full;
            uflow <= i_rd && empty;
        end
    end

    // First word falls through
    assign o_rd_data = mem[rd_ptr];
    assign o_full    = full;
    assign o_empty   = empty;
    assign o_count   = count;
    assign o_oflow   = oflow;
    assign o_uflow   = uflow;
    assign o_wr_ptr  = wr_ptr;
    assign o_rd_ptr  = rd_ptr;

endmodule

/* hw/axil_decoder.sv */
`timescale 1ns/1ps

module fifo_axil_decoder (
    input  logic                            wr_clk,
    input  logic                            i_rst_n,
    // Write address and data
    input  logic                            i_awvalid,
    output logic                            o_awready,
    input  logic [fifo_pkg::AXIL_ADDR_W-1:0] i_awaddr,
    input  logic                            i_wvalid,
    output logic                            o_wready,
    input  logic [fifo_pkg::AXIL_DATA_W-1:0] i_wdata,
    // Write response
    output logic                            o_bvalid,
    input  logic                            i_bready,
    output logic [1:0]                      o_bresp,
    // Read address and data
    input  logic                            i_arvalid,
    output logic                            o_arready,
    input  logic [fifo_pkg::AXIL_ADDR_W-1:0] i_araddr,
    output logic                            o_rvalid,
    input  logic                            i_rready,
    output logic [fifo_pkg::AXIL_DATA_W-1:0] o_rdata,
    output logic [1:0]                      o_rresp,
    // Register block side
    output logic                            o_reg_wr,
    output fifo_pkg::reg_idx_t              o_reg_idx,
    output logic [fifo_pkg::AXIL_DATA_W-1:0] o_reg_wdata,
    input  logic [fifo_pkg::AXIL_DATA_W-1:0] i_reg_rdata
);
    import fifo_pkg::*;

    reg_idx_t wr_idx;
    reg_idx_t rd_idx;
    logic     wr_map;
    logic     rd_map;
    logic     rd_sel;
    logic     wr_stall;
    logic     aw_hs;
    logic     ar_hs;
    logic     bvalid;
    logic     rvalid;

    // Returns 1 for a mapped address
    function automatic logic addr_decode(
        input  logic [AXIL_ADDR_W-1:0] addr,
        output reg_idx_t               idx
    );
        addr_decode = 1'b1;
        idx         = REG_CONTROL;
        case (addr)
            ADDR_CONTROL: idx = REG_CONTROL;
            ADDR_INFO:    idx = REG_INFO;
            ADDR_STATUS:  idx = REG_STATUS;
            ADDR_PTRS:    idx = REG_PTRS;
            default:      addr_decode = 1'b0;
        endcase
    endfunction

    always_comb begin
        wr_map = addr_decode(i_awaddr, wr_idx);
        rd_map = addr_decode(i_araddr, rd_idx);
    end

    // --------------------------------------------------
    // Handshakes and register port arbitration
    // --------------------------------------------------
    assign ar_hs    = i_arvalid && !rvalid;
    assign rd_sel   = ar_hs && rd_map;
    // Read has priority on the register port
    assign wr_stall = rd_sel && wr_map;
    assign aw_hs    = i_awvalid && i_wvalid && !bvalid && !wr_stall;

    assign o_awready   = aw_hs;
    assign o_wready    = aw_hs;
    assign o_arready   = ar_hs;
    assign o_reg_wr    = aw_hs && wr_map;
    assign o_reg_idx   = rd_sel ? rd_idx : wr_idx;
    assign o_reg_wdata = i_wdata;

    // Response valid flags
    always_ff @(posedge wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (aw_hs) begin
                bvalid <= 1'b1;
            end else if (i_bready) begin
                bvalid <= 1'b0;
            end
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (i_rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload stays put while valid
    always_ff @(posedge wr_clk) begin
        if (aw_hs) begin
            o_bresp <= wr_map ? RESP_OKAY : RESP_SLVERR;
        end
        if (ar_hs) begin
            o_rdata <= rd_map ? i_reg_rdata : '0;
            o_rresp <= rd_map ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign o_bvalid = bvalid;
    assign o_rvalid = rvalid;

endmodule

/* hw/fifo_reg_blk.sv */
`timescale 1ns/1ps

module fifo_reg_blk (
    input  logic                            wr_clk,
    input  logic                            i_rst_n,
    // Decoder side
    input  logic                            i_reg_wr,
    input  fifo_pkg::reg_idx_t              i_reg_idx,
    input  logic [fifo_pkg::AXIL_DATA_W-1:0] i_reg_wdata,
    output logic [fifo_pkg::AXIL_DATA_W-1:0] o_reg_rdata,
    // FIFO core side
    input  logic                            i_full,
    input  logic                            i_empty,
    input  logic [fifo_pkg::CNT_W-1:0]      i_count,
    input  logic                            i_oflow,
    input  logic                            i_uflow,
    input  logic [fifo_pkg::PTR_W-1:0]      i_wr_ptr,
    input  logic [fifo_pkg::PTR_W-1:0]      i_rd_ptr,
    output logic                            o_soft_rst
);
    import fifo_pkg::*;

    logic                   soft_rst;
    logic                   oflow_sticky;
    logic                   uflow_sticky;
    logic                   ctrl_wr;
    logic                   stat_wr;
    logic [AXIL_DATA_W-1:0] ctrl_word;
    logic [AXIL_DATA_W-1:0] info_word;
    logic [AXIL_DATA_W-1:0] stat_word;
    logic [AXIL_DATA_W-1:0] ptrs_word;

    assign ctrl_wr = i_reg_wr && (i_reg_idx == REG_CONTROL);
    assign stat_wr = i_reg_wr && (i_reg_idx == REG_STATUS);

    // --------------------------------------------------
    // Control and sticky status
    // --------------------------------------------------
    always_ff @(posedge wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            soft_rst     <= 1'b0;
            oflow_sticky <= 1'b0;
            uflow_sticky <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                soft_rst <= i_reg_wdata[CTRL_SOFT_RST];
            end
            // Set beats write-1-to-clear
            if (i_oflow) begin
                oflow_sticky <= 1'b1;
            end else if (stat_wr && i_reg_wdata[STAT_OFLOW]) begin
                oflow_sticky <= 1'b0;
            end
            if (i_uflow) begin
                uflow_sticky <= 1'b1;
            end else if (stat_wr && i_reg_wdata[STAT_UFLOW]) begin
                uflow_sticky <= 1'b0;
            end
        end
    end

    assign o_soft_rst = soft_rst;

    // --------------------------------------------------
    // Read words
    // --------------------------------------------------
    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_SOFT_RST] = soft_rst;

        info_word = '0;
        info_word[INFO_DEPTH_LSB +: 16] = 16'(FIFO_DEPTH);
        info_word[INFO_WIDTH_LSB +: 8]  = 8'(DATA_W);

        stat_word = '0;
        stat_word[STAT_FULL]  = i_full;
        stat_word[STAT_EMPTY] = i_empty;
        stat_word[STAT_OFLOW] = oflow_sticky;
        stat_word[STAT_UFLOW] = uflow_sticky;
        stat_word[STAT_COUNT_LSB +: CNT_W] = i_count;

        ptrs_word = '0;
        ptrs_word[PTRS_WR_LSB +: PTR_W] = i_wr_ptr;
        ptrs_word[PTRS_RD_LSB +: PTR_W] = i_rd_ptr;
    end

    // Index is always mapped here
    always_comb begin
        case (i_reg_idx)
            REG_CONTROL: o_reg_rdata = ctrl_word;
            REG_INFO:    o_reg_rdata = info_word;
            REG_STATUS:  o_reg_rdata = stat_word;
            REG_PTRS:    o_reg_rdata = ptrs_word;
            default:     o_reg_rdata = '0;
        endcase
    end

endmodule

/* hw/fifo_axil_top.sv */
`timescale 1ns/1ps

module fifo_axil_top (
    input  logic                            wr_clk,
    input  logic                            i_rst_n,
    // AXI4-Lite slave
    input  logic                            i_awvalid,
    output logic                            o_awready,
    input  logic [fifo_pkg::AXIL_ADDR_W-1:0] i_awaddr,
    input  logic                            i_wvalid,
    output logic                            o_wready,
    input  logic [fifo_pkg::AXIL_DATA_W-1:0] i_wdata,
    output logic                            o_bvalid,
    input  logic                            i_bready,
    output logic [1:0]                      o_bresp,
    input  logic                            i_arvalid,
    output logic                            o_arready,
    input  logic [fifo_pkg::AXIL_ADDR_W-1:0] i_araddr,
    output logic                            o_rvalid,
    input  logic                            i_rready,
    output logic [fifo_pkg::AXIL_DATA_W-1:0] o_rdata,
    output logic [1:0]                      o_rresp,
    // FIFO stream
    input  logic                            i_wr,
    input  fifo_pkg::data_t                 i_wr_data,
    output logic                            o_wr_full,
    input  logic                            i_rd,
    output fifo_pkg::data_t                 o_rd_data,
    output logic                            o_rd_empty,
    output logic [fifo_pkg::CNT_W-1:0]      o_count
);
    import fifo_pkg::*;

    logic                   reg_wr;
    reg_idx_t               reg_idx;
    logic [AXIL_DATA_W-1:0] reg_wdata;
    logic [AXIL_DATA_W-1:0] reg_rdata;
    logic                   soft_rst;
    logic                   oflow;
    logic                   uflow;
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    fifo_axil_decoder u_decoder (
        .wr_clk      (wr_clk),
        .i_rst_n     (i_rst_n),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_awaddr    (i_awaddr),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .i_wdata     (i_wdata),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .o_bresp     (o_bresp),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .i_araddr    (i_araddr),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .o_rdata     (o_rdata),
        .o_rresp     (o_rresp),
        .o_reg_wr    (reg_wr),
        .o_reg_idx   (reg_idx),
        .o_reg_wdata (reg_wdata),
        .i_reg_rdata (reg_rdata)
    );

    // Register block
    fifo_reg_blk u_reg_blk (
        .wr_clk      (wr_clk),
        .i_rst_n     (i_rst_n),
        .i_reg_wr    (reg_wr),
        .i_reg_idx   (reg_idx),
        .i_reg_wdata (reg_wdata),
        .o_reg_rdata (reg_rdata),
        .i_full      (o_wr_full),
        .i_empty     (o_rd_empty),
        .i_count     (o_count),
        .i_oflow     (oflow),
        .i_uflow     (uflow),
        .i_wr_ptr    (wr_ptr),
        .i_rd_ptr    (rd_ptr),
        .o_soft_rst  (soft_rst)
    );

    // FIFO core
    fifo_core u_core (
        .wr_clk     (wr_clk),
        .i_rst_n    (i_rst_n),
        .i_soft_rst (soft_rst),
        .i_wr       (i_wr),
        .i_wr_data  (i_wr_data),
        .i_rd       (i_rd),
        .o_rd_data  (o_rd_data),
        .o_full     (o_wr_full),
        .o_empty    (o_rd_empty),
        .o_count    (o_count),
        .o_oflow    (oflow),
        .o_uflow    (uflow),
        .o_wr_ptr   (wr_ptr),
        .o_rd_ptr   (rd_ptr)
    );

endmodule

/* tb/fifo_axil_checker.sv */
`timescale 1ns/1ps

module fifo_axil_checker (
    input  logic                             wr_clk,
    input  logic                             i_rst_n,
    input  logic                             i_full,
    input  logic                             i_empty,
    input  logic [fifo_pkg::CNT_W-1:0]       i_count,
    input  logic                             i_awready,
    input  logic                             i_wready,
    input  logic                             i_arready,
    input  logic                             i_bvalid,
    input  logic                             i_bready,
    input  logic                             i_rvalid,
    input  logic                             i_rready,
    input  logic [fifo_pkg::AXIL_DATA_W-1:0] i_rdata,
    input  logic [1:0]                       i_rresp
);
    import fifo_pkg::*;

    int fail_cnt = 0;

    // --------------------------------------------------
    // FIFO invariants
    // --------------------------------------------------
    full_empty_excl: assert property (@(posedge wr_clk) disable iff (!i_rst_n)
        !(i_full && i_empty))
    else begin
        $error("FIFO full and empty are high together");
        fail_cnt++;
    end

    count_in_range: assert property (@(posedge wr_clk) disable iff (!i_rst_n)
        i_count <= CNT_W'(FIFO_DEPTH))
    else begin
        $error("FIFO count is above the depth");
        fail_cnt++;
    end

    // --------------------------------------------------
    // AXI4-Lite response rules
    // --------------------------------------------------
    bvalid_hold: assert property (@(posedge wr_clk) disable iff (!i_rst_n)
        i_bvalid && !i_bready |=> i_bvalid)
    else begin
        $error("Write response dropped before bready");
        fail_cnt++;
    end

    rdata_stable: assert property (@(posedge wr_clk) disable iff (!i_rst_n)
        i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
    else begin
        $error("Read response changed while stalled");
        fail_cnt++;
    end

    // No new address accepted with a response pending
    aw_blocked: assert property (@(posedge wr_clk) disable iff (!i_rst_n)
        i_bvalid |-> !i_awready && !i_wready)
    else begin
        $error("Write address accepted while bvalid is high");
        fail_cnt++;
    end

    ar_blocked: assert property (@(posedge wr_clk) disable iff (!i_rst_n)
        i_rvalid |-> !i_arready)
    else begin
        $error("Read address accepted while rvalid is high");
        fail_cnt++;
    end

endmodule

/* tb/tb_fifo_axil.sv */
`timescale 1ns/1ps

module tb_fifo_axil;
    import fifo_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 6;

    logic                   wr_clk = 1'b0;
    logic                   rst_n;
    logic                   awvalid, wvalid, bready, arvalid, rready, wr, rd;
    logic                   awready, wready, bvalid, arready, rvalid, wr_full, rd_empty;
    logic [AXIL_ADDR_W-1:0] awaddr, araddr;
    logic [AXIL_DATA_W-1:0] wdata, rdata;
    logic [1:0]             bresp, rresp;
    data_t                  wr_data, rd_data;
    logic [CNT_W-1:0]       count;

    int          errors    = 0;
    int          checks    = 0;
    logic [31:0] lcg_state = 32'h5a4a745c;
    data_t       model_q[$];

    always #(CLK_PERIOD / 2) wr_clk = ~wr_clk;

    fifo_axil_top u_fifo_axil_top (
        .wr_clk (wr_clk), .i_rst_n (rst_n),
        .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr),
        .i_wvalid (wvalid), .o_wready (wready), .i_wdata (wdata),
        .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
        .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr),
        .o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata), .o_rresp (rresp),
        .i_wr (wr), .i_wr_data (wr_data), .o_wr_full (wr_full),
        .i_rd (rd), .o_rd_data (rd_data), .o_rd_empty (rd_empty), .o_count (count)
    );

    bind fifo_axil_top fifo_axil_checker u_checker (
        .wr_clk (wr_clk), .i_rst_n (i_rst_n), .i_full (o_wr_full), .i_empty (o_rd_empty),
        .i_count (o_count), .i_awready (o_awready), .i_wready (o_wready),
        .i_arready (o_arready), .i_bvalid (o_bvalid), .i_bready (i_bready),
        .i_rvalid (o_rvalid), .i_rready (i_rready), .i_rdata (o_rdata), .i_rresp (o_rresp)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic data_t lcg_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // Expected STATUS word from the queue model
    function automatic logic [31:0] status_expect(input logic oflow, input logic uflow);
        logic [31:0] w;
        w = 32'h0;
        w[0] = (model_q.size() == FIFO_DEPTH);
        w[1] = (model_q.size() == 0);
        w[2] = oflow;
        w[3] = uflow;
        w[11:8] = 4'(model_q.size());
        return w;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        assert (actual === expected) else begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        @(posedge wr_clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        do begin
            @(negedge wr_clk);
        end while (!awready);
        @(posedge wr_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        do begin
            @(negedge wr_clk);
        end while (!bvalid);
        resp = bresp;
        @(posedge wr_clk);
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge wr_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        do begin
            @(negedge wr_clk);
        end while (!arready);
        @(posedge wr_clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do begin
            @(negedge wr_clk);
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge wr_clk);
        rready <= 1'b0;
    endtask

    task automatic check_status(input logic oflow, input logic uflow);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(ADDR_STATUS, data, resp);
        check_value(data, status_expect(oflow, uflow), "STATUS");
        check_value(32'(resp), 32'(RESP_OKAY), "STATUS response");
    endtask

    // Model follows the accepting edge
    task automatic fifo_push(input data_t d);
        logic accepted;
        @(posedge wr_clk);
        wr      <= 1'b1;
        wr_data <= d;
        @(negedge wr_clk);
        accepted = !wr_full;
        check_value(32'(accepted), 32'(model_q.size() < FIFO_DEPTH), "push accepted");
        @(posedge wr_clk);
        wr <= 1'b0;
        if (accepted && model_q.size() < FIFO_DEPTH) begin
            model_q.push_back(d);
        end
    endtask

    task automatic fifo_pop();
        logic ok;
        @(posedge wr_clk);
        rd <= 1'b1;
        @(negedge wr_clk);
        check_value(32'(!rd_empty), 32'(model_q.size() != 0), "pop accepted");
        ok = !rd_empty && (model_q.size() != 0);
        if (ok) begin
            check_value(32'(rd_data), 32'(model_q[0]), "popped word");
        end
        @(posedge wr_clk);
        rd <= 1'b0;
        if (ok) begin
            void'(model_q.pop_front());
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_mark);
        $display("Test %0d %s finished with %0d errors", num, name, errors - err_mark);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        int          err_mark;
        int          n_aw;
        int          n_ar;
        rst_n <= 1'b0;
        {awvalid, wvalid, bready, arvalid, rready, wr, rd} <= '0;
        {awaddr, araddr, wdata, wr_data} <= '0;
        repeat (5) @(posedge wr_clk);
        rst_n <= 1'b1;

        err_mark = errors;
        @(negedge wr_clk);
        check_value(32'(rd_empty), 32'd1, "empty after reset");
        check_value(32'(wr_full), 32'd0, "full after reset");
        check_value(32'({bvalid, rvalid}), 32'd0, "response valid after reset");
        axil_read(ADDR_INFO, data, resp);
        check_value(data, 32'h0010_0008, "INFO");
        check_value(32'(resp), 32'(RESP_OKAY), "INFO response");
        end_test(1, "reset state", err_mark);

        err_mark = errors;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            fifo_push(lcg_word());
        end
        @(negedge wr_clk);
        check_value(32'(wr_full), 32'd1, "full after 8 pushes");
        check_value(32'(count), 32'd8, "count after 8 pushes");
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            fifo_pop();
        end
        @(negedge wr_clk);
        check_value(32'(rd_empty), 32'd1, "empty after draining");
        end_test(2, "order and full", err_mark);

        // Dropped push, then dropped pop
        err_mark = errors;
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            fifo_push(lcg_word());
        end
        check_status(1'b1, 1'b0);
        axil_write(ADDR_STATUS, 32'h4, resp);
        check_status(1'b0, 1'b0);
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            fifo_pop();
        end
        check_status(1'b0, 1'b1);
        axil_write(ADDR_STATUS, 32'h8, resp);
        check_status(1'b0, 1'b0);
        end_test(3, "overflow and underflow", err_mark);

        err_mark = errors;
        for (int i = 0; i < 3; i++) begin
            fifo_push(lcg_word());
        end
        axil_write(ADDR_CONTROL, 32'h1, resp);
        model_q.delete();
        @(negedge wr_clk);
        check_value(32'(rd_empty), 32'd1, "empty in soft reset");
        check_value(32'(count), 32'd0, "count in soft reset");
        axil_read(ADDR_CONTROL, data, resp);
        check_value(data, 32'h1, "CONTROL");
        axil_write(ADDR_CONTROL, 32'h0, resp);
        fifo_push(lcg_word());
        fifo_pop();
        end_test(4, "soft reset", err_mark);

        // Sticky bit and one stored word make a stray write visible in STATUS
        err_mark = errors;
        fifo_pop();
        fifo_push(lcg_word());
        check_status(1'b0, 1'b1);
        axil_write(8'h40, 32'hffff_ffff, resp);
        check_value(32'(resp), 32'(RESP_SLVERR), "unmapped write response");
        axil_read(8'h40, data, resp);
        check_value(32'(resp), 32'(RESP_SLVERR), "unmapped read response");
        check_value(data, 32'h0, "unmapped read data");
        check_status(1'b0, 1'b1);
        end_test(5, "unmapped address", err_mark);

        // Both channels stalled with new requests waiting
        err_mark = errors;
        n_aw = 0;
        n_ar = 0;
        @(posedge wr_clk);
        {awvalid, wvalid, arvalid} <= 3'b111;
        awaddr <= ADDR_STATUS;
        wdata  <= 32'h0;
        araddr <= ADDR_INFO;
        while (n_aw == 0 || n_ar == 0) begin
            @(negedge wr_clk);
            n_aw = awready ? n_aw + 1 : n_aw;
            n_ar = arready ? n_ar + 1 : n_ar;
        end
        repeat (10) begin
            @(negedge wr_clk);
            n_aw = awready ? n_aw + 1 : n_aw;
            n_ar = arready ? n_ar + 1 : n_ar;
            check_value(32'({bvalid, rvalid}), 32'h3, "valid under back-pressure");
            check_value(rdata, 32'h0010_0008, "held read data");
            check_value(32'({bresp, rresp}), 32'h0, "held responses");
        end
        check_value(32'(n_aw), 32'd1, "write address handshakes");
        check_value(32'(n_ar), 32'd1, "read address handshakes");
        @(posedge wr_clk);
        {awvalid, wvalid, arvalid} <= 3'b000;
        {bready, rready} <= 2'b11;
        @(posedge wr_clk);
        {bready, rready} <= 2'b00;
        @(negedge wr_clk);
        check_value(32'({bvalid, rvalid}), 32'h0, "valid after release");
        end_test(6, "back-pressure", err_mark);

        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d", NUM_TESTS,
                 checks, errors, u_fifo_axil_top.u_checker.fail_cnt);
        if (errors == 0 && u_fifo_axil_top.u_checker.fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("Run timed out after %0d ns, a handshake never completed", $time);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* files.f */
hw/fifo_pkg.sv
hw/fifo_core.sv
hw/axil_decoder.sv
hw/fifo_reg_blk.sv
hw/fifo_axil_top.sv
tb/fifo_axil_checker.sv
tb/tb_fifo_axil.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fifo_axil -f files.f -o tb_fifo_axil \
    || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/tb_fifo_axil +verilator+error+limit+100 2>&1)
echo "$sim_out"
grep -q "TESTS PASSED" <<< "$sim_out" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
